/* exc_subsys.f */
hdl/exc_pkg.sv
hdl/exc_ctrl_if.sv
hdl/irq_sync.sv
hdl/exc_controller.sv
hdl/exc_pc_unit.sv
hdl/exc_subsys.sv
tests/tb_clk_gen.sv
tests/exc_subsys_props.sv
tests/tb_exc_subsys.sv

/* hdl/exc_controller.sv */
// exception controller
// ranks illegal insn, interrupts and a stray return from exception,
// defers an irq behind an in-flight jump, blocks nesting and hands
// the event to the debug unit when the dsr asks for it

`timescale 1ns/1ns

module exc_controller (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              fetch_enable_i,         // core allowed to fetch

  // interrupts, already synchronized
  input  logic              irq_i,
  input  logic              irq_nm_i,
  input  logic              irq_enable_i,           // global enable
  output logic              irq_present_o,          // wake-up hint

  // pipeline status
  input  logic              illegal_insn_i,         // illegal insn in id
  input  logic              trap_insn_i,            // trap insn in id
  input  logic              clear_isr_running_i,    // return from exception
  input  logic              stall_id_i,
  input  exc_pkg::jump_e    jump_in_id_i,
  input  exc_pkg::jump_e    jump_in_ex_i,
  output logic              exc_pipe_flush_o,       // flush and sleep

  // debug unit
  input  logic              dbg_flush_pipe_i,       // halt request
  input  logic              dbg_st_en_i,            // single step
  input  logic [1:0]        dbg_dsr_i,              // debug stop register
  output logic              trap_hit_o,

  exc_ctrl_if.ctrl          exc_o                   // request to pc unit
);

  exc_pkg::exc_reason_e exc_reason;                 // decoded, after override
  exc_pkg::exc_reason_e exc_reason_d, exc_reason_q; // deferral state

  logic exc_running_d, exc_running_q;               // inside a handler
  logic new_instr_id_q;                             // id insn arrived last cycle

  logic              exc_pc_sel;
  exc_pkg::exc_vec_e exc_vec;
  logic              save_pc_if;
  logic              save_pc_id;

  logic              jump_defer;                    // irq must wait one cycle
  exc_pkg::exc_vec_e irq_vec;                       // nm beats normal irq

  ////////////////////
  // decoder
  ////////////////////

  assign irq_present_o = (irq_i || irq_nm_i) && irq_enable_i;

  // debug trap sources, nesting only matters for the irq case
  assign trap_hit_o = trap_insn_i || dbg_flush_pipe_i || dbg_st_en_i
                    || (illegal_insn_i && dbg_dsr_i[exc_pkg::DSR_IIE])
                    || (irq_present_o && dbg_dsr_i[exc_pkg::DSR_INTE] && !exc_running_q);

  always_comb
  begin
    exc_reason       = exc_pkg::EXC_NONE;
    exc_pipe_flush_o = 1'b0;

    if (illegal_insn_i)
    begin
      // dsr may steal it for the debugger
      if (!dbg_dsr_i[exc_pkg::DSR_IIE] && !exc_running_q)
        exc_reason = exc_pkg::EXC_ILLEGAL;
    end
    else if (irq_present_o && !exc_running_q)
    begin
      if (!dbg_dsr_i[exc_pkg::DSR_INTE])
        exc_reason = exc_pkg::EXC_IR;
    end
    else if (clear_isr_running_i)
    begin
      if (!exc_running_q)
        exc_reason = exc_pkg::EXC_ILLEGAL;          // return with nothing to return from
      else if (!fetch_enable_i)
        exc_pipe_flush_o = 1'b1;                    // leave handler and go to sleep
    end

    // a pending deferral wins over whatever is decoded now
    if (exc_reason_q != exc_pkg::EXC_NONE)
      exc_reason = exc_reason_q;
  end

  ////////////////////
  // request generation
  ////////////////////

  // jal/jalr still resolving in id, or a branch deciding in ex
  assign jump_defer = (((jump_in_id_i == exc_pkg::JUMP_JAL)
                     || (jump_in_id_i == exc_pkg::JUMP_JALR)) && !new_instr_id_q)
                    || (jump_in_ex_i == exc_pkg::JUMP_COND);

  assign irq_vec = irq_nm_i ? exc_pkg::EXC_VEC_IRQ_NM : exc_pkg::EXC_VEC_IRQ;

  always_comb
  begin
    exc_pc_sel    = 1'b0;
    exc_vec       = exc_pkg::EXC_VEC_NONE;
    save_pc_if    = 1'b0;
    save_pc_id    = 1'b0;
    exc_reason_d  = exc_pkg::EXC_NONE;
    exc_running_d = exc_running_q;

    // leaving the handler
    if (clear_isr_running_i && exc_running_q)
      exc_running_d = 1'b0;

    case (exc_reason)
      exc_pkg::EXC_IR:
      begin
        if (jump_defer)
        begin
          if (!stall_id_i)
            exc_reason_d = exc_pkg::EXC_IR_DEFERRED;  // go next cycle
        end
        else
        begin
          exc_pc_sel    = 1'b1;
          exc_vec       = irq_vec;
          exc_running_d = 1'b1;
          save_pc_id    = (jump_in_id_i != exc_pkg::JUMP_NONE);  // jump in id not done yet
          save_pc_if    = (jump_in_id_i == exc_pkg::JUMP_NONE);
        end
      end
      exc_pkg::EXC_IR_DEFERRED:
      begin
        // irq may have dropped meanwhile, normal vector then
        exc_pc_sel    = 1'b1;
        exc_vec       = irq_vec;
        exc_running_d = 1'b1;
        save_pc_id    = (jump_in_id_i != exc_pkg::JUMP_NONE);
        save_pc_if    = (jump_in_id_i == exc_pkg::JUMP_NONE);
      end
      exc_pkg::EXC_ILLEGAL:
      begin
        exc_pc_sel    = 1'b1;
        exc_vec       = exc_pkg::EXC_VEC_ILLINSN;
        exc_running_d = 1'b1;
        save_pc_id    = 1'b1;                       // faulting insn sits in id
      end
      default:
      begin
        exc_reason_d = exc_pkg::EXC_NONE;           // nothing to do
      end
    endcase
  end

  assign exc_o.exc_pc_sel = exc_pc_sel;
  assign exc_o.exc_vec    = exc_vec;
  assign exc_o.save_pc_if = save_pc_if;
  assign exc_o.save_pc_id = save_pc_id;

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      exc_running_q  <= 1'b0;
      new_instr_id_q <= 1'b0;
      exc_reason_q   <= exc_pkg::EXC_NONE;
    end
    else
    begin
      exc_running_q  <= exc_running_d;
      new_instr_id_q <= !stall_id_i;                // id moves on when not stalled
      exc_reason_q   <= exc_reason_d;
    end
  end

endmodule

/* hdl/exc_ctrl_if.sv */
// exception request bus from controller to pc unit
// one-cycle request, always accepted, no handshake back

`timescale 1ns/1ns

interface exc_ctrl_if;

  logic                exc_pc_sel;                  // redirect fetch this cycle
  exc_pkg::exc_vec_e   exc_vec;                     // which handler
  logic                save_pc_if;                  // capture if-stage pc as epc
  logic                save_pc_id;                  // capture id-stage pc as epc

  // controller side
  modport ctrl (
    output exc_pc_sel,
    output exc_vec,
    output save_pc_if,
    output save_pc_id
  );

  // pc unit side
  modport pcu (
    input  exc_pc_sel,
    input  exc_vec,
    input  save_pc_if,
    input  save_pc_id
  );

endinterface

/* hdl/exc_pc_unit.sv */
// exception pc unit
// turns the vector selection into a handler address and keeps
// the epc captured from the if or id stage

`timescale 1ns/1ns

module exc_pc_unit #(
  parameter logic [exc_pkg::ADDR_W-1:0] VECTOR_BASE = 32'h0000_0100
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [exc_pkg::ADDR_W-1:0] pc_if_i,       // pc of insn in if
  input  logic [exc_pkg::ADDR_W-1:0] pc_id_i,       // pc of insn in id
  exc_ctrl_if.pcu                    exc_i,
  output logic [exc_pkg::ADDR_W-1:0] exc_pc_o,      // handler address
  output logic                       exc_pc_valid_o,
  output logic [exc_pkg::ADDR_W-1:0] epc_o          // saved return pc
);

  logic [exc_pkg::ADDR_W-1:0] vec_ext;              // selection, zero extended
  logic [exc_pkg::ADDR_W-1:0] vec_offset;
  logic [exc_pkg::ADDR_W-1:0] epc_q;

  ////////////////////
  // vector address
  ////////////////////

  assign vec_ext    = {{(exc_pkg::ADDR_W-2){1'b0}}, exc_i.exc_vec};
  assign vec_offset = vec_ext * exc_pkg::VEC_STRIDE;

  // address only shown while a request is up
  always_comb
  begin
    if (exc_i.exc_pc_sel)
      exc_pc_o = VECTOR_BASE + vec_offset;
    else
      exc_pc_o = '0;
  end

  assign exc_pc_valid_o = exc_i.exc_pc_sel;         // every request is taken

  ////////////////////
  // epc
  ////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      epc_q <= '0;
    end
    else if (exc_i.save_pc_id)
    begin
      epc_q <= pc_id_i;                             // jump or illegal in id
    end
    else if (exc_i.save_pc_if)
    begin
      epc_q <= pc_if_i;
    end
  end

  assign epc_o = epc_q;

endmodule

/* hdl/exc_pkg.sv */
// exception front end shared definitions
// vector selection, jump kinds, controller reason state and
// debug stop register bit positions

package exc_pkg;

  ////////////////////
  // widths and spacing
  ////////////////////

  localparam int ADDR_W = 32;                       // pc / vector address width

  // byte distance between two neighbouring exception vectors
  localparam logic [ADDR_W-1:0] VEC_STRIDE = 32'd4;

  // debug stop register, 2 bits
  localparam int DSR_IIE  = 0;                      // illegal insn goes to debug
  localparam int DSR_INTE = 1;                      // interrupt goes to debug

  ////////////////////
  // enums
  ////////////////////

  typedef enum logic [1:0] {
    EXC_VEC_NONE    = 2'd0,                         // no redirect
    EXC_VEC_IRQ     = 2'd1,                         // maskable irq handler
    EXC_VEC_IRQ_NM  = 2'd2,                         // non-maskable irq handler
    EXC_VEC_ILLINSN = 2'd3                          // illegal insn handler
  } exc_vec_e;

  typedef enum logic [1:0] {
    JUMP_NONE = 2'd0,
    JUMP_JAL  = 2'd1,
    JUMP_JALR = 2'd2,
    JUMP_COND = 2'd3                                // conditional branch
  } jump_e;

  // controller reason, also the registered deferral state
  typedef enum logic [1:0] {
    EXC_NONE,
    EXC_IR,
    EXC_IR_DEFERRED,
    EXC_ILLEGAL
  } exc_reason_e;

endpackage

/* hdl/exc_subsys.sv */
// exception and interrupt front end, top level
// irq synchronizer, exception controller and exception pc unit

`timescale 1ns/1ns

module exc_subsys #(
  parameter logic [exc_pkg::ADDR_W-1:0] VECTOR_BASE = 32'h0000_0100,
  parameter int                         SYNC_STAGES = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_enable_i,
  input  logic                       irq_i,         // async
  input  logic                       irq_nm_i,      // async
  input  logic                       irq_enable_i,
  input  logic                       illegal_insn_i,
  input  logic                       trap_insn_i,
  input  logic                       clear_isr_running_i,
  input  logic                       stall_id_i,
  input  logic                       dbg_flush_pipe_i,
  input  logic                       dbg_st_en_i,
  input  exc_pkg::jump_e             jump_in_id_i,
  input  exc_pkg::jump_e             jump_in_ex_i,
  input  logic [1:0]                 dbg_dsr_i,
  input  logic [exc_pkg::ADDR_W-1:0] pc_if_i,
  input  logic [exc_pkg::ADDR_W-1:0] pc_id_i,
  output logic [exc_pkg::ADDR_W-1:0] exc_pc_o,
  output logic                       exc_pc_valid_o,
  output logic [exc_pkg::ADDR_W-1:0] epc_o,
  output logic                       irq_present_o,
  output logic                       exc_pipe_flush_o,
  output logic                       trap_hit_o
);

  logic irq_sync;                                   // irq in clk domain
  logic irq_nm_sync;

  exc_ctrl_if exc_bus ();                           // controller to pc unit

  irq_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_irq_sync (
    .clk           (clk),
    .rst_n         (rst_n),
    .irq_i         (irq_i),
    .irq_nm_i      (irq_nm_i),
    .irq_sync_o    (irq_sync),
    .irq_nm_sync_o (irq_nm_sync)
  );

  exc_controller u_exc_controller (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .irq_i               (irq_sync),
    .irq_nm_i            (irq_nm_sync),
    .irq_enable_i        (irq_enable_i),
    .irq_present_o       (irq_present_o),
    .illegal_insn_i      (illegal_insn_i),
    .trap_insn_i         (trap_insn_i),
    .clear_isr_running_i (clear_isr_running_i),
    .stall_id_i          (stall_id_i),
    .jump_in_id_i        (jump_in_id_i),
    .jump_in_ex_i        (jump_in_ex_i),
    .exc_pipe_flush_o    (exc_pipe_flush_o),
    .dbg_flush_pipe_i    (dbg_flush_pipe_i),
    .dbg_st_en_i         (dbg_st_en_i),
    .dbg_dsr_i           (dbg_dsr_i),
    .trap_hit_o          (trap_hit_o),
    .exc_o               (exc_bus.ctrl)
  );

  exc_pc_unit #(
    .VECTOR_BASE (VECTOR_BASE)
  ) u_exc_pc_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .exc_i          (exc_bus.pcu),
    .exc_pc_o       (exc_pc_o),
    .exc_pc_valid_o (exc_pc_valid_o),
    .epc_o          (epc_o)
  );

endmodule

/* hdl/irq_sync.sv */
// interrupt line synchronizer
// flop chain of SYNC_STAGES per line (min 2), both lines share one vector

`timescale 1ns/1ns

module irq_sync #(
  parameter int SYNC_STAGES = 2                     // depth, at least 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic irq_i,                               // async, level
  input  logic irq_nm_i,                            // async, level
  output logic irq_sync_o,
  output logic irq_nm_sync_o
);

  // bit 0 carries irq, bit 1 carries irq_nm
  logic [SYNC_STAGES-1:0][1:0] stage_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      stage_q <= '0;
    end
    else
    begin
      // stage 0 is the only flop that sees the raw lines
      stage_q <= {stage_q[SYNC_STAGES-2:0], {irq_nm_i, irq_i}};
    end
  end

  assign irq_sync_o    = stage_q[SYNC_STAGES-1][0];   // last stage only
  assign irq_nm_sync_o = stage_q[SYNC_STAGES-1][1];

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the exception front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_exc_subsys \
  --Mdir obj_dir -o sim_exc_subsys \
  -f exc_subsys.f

# the log decides the result, so a non-zero exit here must not stop the script
./obj_dir/sim_exc_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "run_sim: testbench reported failure"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: simulation ended without a result"
  exit 1
fi
echo "run_sim: done"

/* tests/exc_subsys_props.sv */
// exception controller properties
// bound into every exc_controller, watches the request bus and state

`timescale 1ns/1ns

module exc_subsys_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 exc_pc_sel_i,
  input logic                 save_pc_if_i,
  input logic                 save_pc_id_i,
  input logic                 exc_running_i,
  input exc_pkg::exc_reason_e exc_reason_i
);

  ////////////////////
  // request rules
  ////////////////////

  // no nesting, only an already decided deferral may still fire
  no_nested_req: assert property (@(posedge clk) disable iff (!rst_n)
    (exc_pc_sel_i && exc_running_i) |-> (exc_reason_i == exc_pkg::EXC_IR_DEFERRED))
    else $error("exception request while a handler is running");

  one_save_src: assert property (@(posedge clk) disable iff (!rst_n)
    !(save_pc_if_i && save_pc_id_i))                // epc has a single source
    else $error("if and id pc saved in the same cycle");

  // quiet bus while reset is applied
  no_req_in_reset: assert property (@(posedge clk) !rst_n |-> !exc_pc_sel_i)
    else $error("exception request during reset");

endmodule

bind exc_controller exc_subsys_props u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .exc_pc_sel_i  (exc_pc_sel),
  .save_pc_if_i  (save_pc_if),
  .save_pc_id_i  (save_pc_id),
  .exc_running_i (exc_running_q),
  .exc_reason_i  (exc_reason_q)
);

/* tests/tb_clk_gen.sv */
// testbench clock source
// free running square wave, 20 ns period by default

`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;                                   // first edge is a rising one
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

/* tests/tb_exc_subsys.sv */
// directed testbench for the exception front end
// illegal insn, interrupts, deferral, debug redirection, return handling

`timescale 1ns/1ns

module tb_exc_subsys;

  localparam logic [31:0] VECTOR_BASE = 32'h0000_0100;
  localparam int SYNC_STAGES = 2;
  localparam int WAIT_LIMIT  = 8;                   // cycles before a wait gives up
  localparam int VEC_IRQ     = 1;                   // vector slots as encoded
  localparam int VEC_NM      = 2;
  localparam int VEC_ILL     = 3;

  logic clk, rst_n;
  logic fetch_enable_i, irq_i, irq_nm_i, irq_enable_i;
  logic illegal_insn_i, trap_insn_i, clear_isr_running_i, stall_id_i;
  logic dbg_flush_pipe_i, dbg_st_en_i;
  exc_pkg::jump_e jump_in_id_i, jump_in_ex_i;
  logic [1:0]  dbg_dsr_i;
  logic [31:0] pc_if_i, pc_id_i, exc_pc_o, epc_o;
  logic exc_pc_valid_o, irq_present_o, exc_pipe_flush_o, trap_hit_o;
  int   seed;

  tb_clk_gen #(.PERIOD_NS(20)) u_clk_gen (.clk_o(clk));

  exc_subsys #(
    .VECTOR_BASE (VECTOR_BASE),
    .SYNC_STAGES (SYNC_STAGES)
  ) dut_i (.*);

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // handler address from base and slot number
  function automatic logic [31:0] vector_addr(input int slot);
    return VECTOR_BASE + 32'(slot) * exc_pkg::VEC_STRIDE;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic new_pcs();
    pc_if_i = $random(seed);
    pc_id_i = $random(seed);
  endtask

  // count falling edges until valid is seen 2 ns after one
  task automatic wait_valid(input int limit, output int cycles);
    cycles = 0;
    while (exc_pc_valid_o !== 1'b1)
    begin
      if (cycles >= limit)
        abort_run("Timeout: exc_pc_valid_o never rose while an exception was expected");
      else
      begin
        @(negedge clk);
        #2;
        cycles++;
      end
    end
  endtask

  // return from handler once the synced irq lines are low again
  task automatic leave_handler();
    idle(SYNC_STAGES + 2);
    clear_isr_running_i = 1'b1;
    #2;
    check_val("exc_pipe_flush_o", 32'(exc_pipe_flush_o), 32'd0);
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    clear_isr_running_i = 1'b0;
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_values();
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd0);
    check_val("exc_pipe_flush_o", 32'(exc_pipe_flush_o), 32'd0);
    check_val("irq_present_o", 32'(irq_present_o), 32'd0);
    check_val("epc_o", epc_o, 32'd0);
    check_val("exc_pc_o", exc_pc_o, 32'd0);
  endtask

  task automatic test_illegal();
    logic [31:0] faulting_pc;
    @(negedge clk);
    new_pcs();
    faulting_pc    = pc_id_i;
    illegal_insn_i = 1'b1;
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd1);    // same cycle
    check_val("exc_pc_o", exc_pc_o, vector_addr(VEC_ILL));
    @(negedge clk);
    illegal_insn_i = 1'b0;
    new_pcs();
    #2;
    check_val("epc_o", epc_o, faulting_pc);
    @(negedge clk);
    illegal_insn_i = 1'b1;                          // nested one is ignored
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    illegal_insn_i = 1'b0;
    leave_handler();
    illegal_insn_i = 1'b1;
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd1);
    @(negedge clk);
    illegal_insn_i = 1'b0;
    leave_handler();
  endtask

  // take one interrupt with optional nm and check its vector after the sync delay
  task automatic take_irq(input logic with_nm, input int slot);
    int cycles;
    @(negedge clk);
    new_pcs();
    irq_i    = 1'b1;
    irq_nm_i = with_nm;
    #2;
    wait_valid(WAIT_LIMIT, cycles);
    check_val("irq latency", 32'(cycles), 32'(SYNC_STAGES));
    check_val("exc_pc_o", exc_pc_o, vector_addr(slot));
    check_val("irq_present_o", 32'(irq_present_o), 32'd1);
    @(negedge clk);
    irq_i    = 1'b0;
    irq_nm_i = 1'b0;
    #2;
    check_val("epc_o", epc_o, pc_if_i);             // no jump in id
    leave_handler();
  endtask

  task automatic test_interrupts();
    take_irq(1'b0, VEC_IRQ);
    take_irq(1'b1, VEC_NM);
    @(negedge clk);
    irq_enable_i = 1'b0;                            // masked
    irq_i        = 1'b1;
    repeat (SYNC_STAGES + 3)
    begin
      @(negedge clk);
      #2;
      check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
      check_val("irq_present_o", 32'(irq_present_o), 32'd0);
    end
    irq_i = 1'b0;
    idle(SYNC_STAGES + 1);
    irq_enable_i = 1'b1;
  endtask

  task automatic test_deferral();
    int cycles;
    @(negedge clk);
    new_pcs();
    jump_in_ex_i = exc_pkg::JUMP_COND;              // branch resolving in ex
    jump_in_id_i = exc_pkg::JUMP_JAL;
    irq_i        = 1'b1;
    #2;
    wait_valid(WAIT_LIMIT, cycles);
    check_val("deferred latency", 32'(cycles), 32'(SYNC_STAGES + 1));
    check_val("exc_pc_o", exc_pc_o, vector_addr(VEC_IRQ));
    @(negedge clk);
    irq_i        = 1'b0;
    jump_in_ex_i = exc_pkg::JUMP_NONE;
    jump_in_id_i = exc_pkg::JUMP_NONE;
    #2;
    check_val("epc_o", epc_o, pc_id_i);             // jump still in id
    leave_handler();
    // jal in a stalled id holds the request back
    jump_in_id_i = exc_pkg::JUMP_JAL;
    stall_id_i   = 1'b1;
    irq_i        = 1'b1;
    repeat (SYNC_STAGES + 4)
    begin
      @(negedge clk);
      #2;
      check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    end
    check_val("irq_present_o", 32'(irq_present_o), 32'd1);
    @(negedge clk);
    stall_id_i = 1'b0;                              // jal not new in this cycle
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    wait_valid(WAIT_LIMIT, cycles);
    check_val("post-stall latency", 32'(cycles), 32'd1);
    check_val("exc_pc_o", exc_pc_o, vector_addr(VEC_IRQ));
    @(negedge clk);
    irq_i        = 1'b0;
    jump_in_id_i = exc_pkg::JUMP_NONE;
    #2;
    check_val("epc_o", epc_o, pc_id_i);             // jal held in id
    leave_handler();
  endtask

  task automatic test_debug();
    @(negedge clk);
    dbg_dsr_i[exc_pkg::DSR_IIE] = 1'b1;
    illegal_insn_i = 1'b1;
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd1);
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    illegal_insn_i = 1'b0;
    dbg_dsr_i      = 2'b00;
    dbg_dsr_i[exc_pkg::DSR_INTE] = 1'b1;
    irq_i = 1'b1;
    idle(SYNC_STAGES);                              // line now through the sync
    #2;
    check_val("irq_present_o", 32'(irq_present_o), 32'd1);
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd1);
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    irq_i = 1'b0;
    idle(SYNC_STAGES + 1);
    dbg_dsr_i   = 2'b00;
    trap_insn_i = 1'b1;
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd1);
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    trap_insn_i = 1'b0;
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd0);
    @(negedge clk);
    dbg_flush_pipe_i = 1'b1;                        // halt request
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd1);
    @(negedge clk);
    dbg_flush_pipe_i = 1'b0;
    dbg_st_en_i      = 1'b1;                        // single step
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd1);
    @(negedge clk);
    dbg_st_en_i = 1'b0;
    #2;
    check_val("trap_hit_o", 32'(trap_hit_o), 32'd0);
  endtask

  task automatic test_return();
    @(negedge clk);
    clear_isr_running_i = 1'b1;                     // stray return
    #2;
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd1);
    check_val("exc_pc_o", exc_pc_o, vector_addr(VEC_ILL));
    @(negedge clk);
    clear_isr_running_i = 1'b0;
    leave_handler();
    illegal_insn_i = 1'b1;                          // enter a handler first
    @(negedge clk);
    illegal_insn_i      = 1'b0;
    clear_isr_running_i = 1'b1;
    fetch_enable_i      = 1'b0;                     // return and sleep
    #2;
    check_val("exc_pipe_flush_o", 32'(exc_pipe_flush_o), 32'd1);
    check_val("exc_pc_valid_o", 32'(exc_pc_valid_o), 32'd0);
    @(negedge clk);
    clear_isr_running_i = 1'b0;
    fetch_enable_i      = 1'b1;
    #2;
    check_val("exc_pipe_flush_o", 32'(exc_pipe_flush_o), 32'd0);
  endtask

  ////////////////////
  // sequence
  ////////////////////

  initial
  begin
    seed = 32'hebbb;
    rst_n = 1'b0;
    fetch_enable_i = 1'b1;
    {irq_i, irq_nm_i, illegal_insn_i, trap_insn_i} = 4'b0000;
    {clear_isr_running_i, stall_id_i, dbg_flush_pipe_i, dbg_st_en_i} = 4'b0000;
    irq_enable_i = 1'b1;
    jump_in_id_i = exc_pkg::JUMP_NONE;
    jump_in_ex_i = exc_pkg::JUMP_NONE;
    dbg_dsr_i    = 2'b00;
    new_pcs();
    idle(16);                                       // reset for 16 cycles
    rst_n = 1'b1;
    test_reset_values();
    test_illegal();
    test_interrupts();
    test_deferral();
    test_debug();
    test_return();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
